/* Bender.yml */
package:
  name: fdd_track

sources:
  - logic/fdd_geometry_pkg.sv
  - logic/fdd_sd_pkg.sv
  - logic/head_stepper.sv
  - logic/media_table.sv
  - logic/track_loader.sv
  - logic/track_buffer_ram.sv
  - logic/fdd_track.sv
  - target: simulation
    files:
      - sim/sd_card_model.sv
      - sim/tb_fdd_track.sv

/* fdd_track.f */
logic/fdd_geometry_pkg.sv
logic/fdd_sd_pkg.sv
logic/head_stepper.sv
logic/media_table.sv
logic/track_loader.sv
logic/track_buffer_ram.sv
logic/fdd_track.sv
sim/sd_card_model.sv
sim/tb_fdd_track.sv

/* logic/fdd_geometry_pkg.sv */
package fdd_geometry_pkg;

    // ********************
    // Types
    // ********************

    // Cylinder number, 0 .. max_track.
    typedef logic [6:0] track_t;

    // One of the four drive slots.
    typedef logic [1:0] drive_sel_t;

    // Byte offset inside the track buffer.
    typedef logic [12:0] buf_addr_t;

    typedef logic [7:0] byte_t;

    // ********************
    // Geometry
    // ********************

    localparam int unsigned num_drives = 4;

    // Highest cylinder the head can reach.
    localparam int unsigned max_track = 79;

    // Head position after reset.
    localparam int unsigned reset_track = 3;

    // Step lockout, in millisecond ticks.
    localparam int unsigned step_delay_ms = 3;

    localparam int unsigned sectors_per_track = 9;

    // Nine sectors of 512 bytes.
    localparam int unsigned track_bytes = 4608;

endpackage

/* logic/fdd_sd_pkg.sv */
package fdd_sd_pkg;

    // ********************
    // Block access
    // ********************

    // SD block address.
    typedef logic [31:0] lba_t;

    // Number of blocks in one request.
    typedef logic [5:0] blk_cnt_t;

    // Byte offset within one transfer.
    typedef logic [13:0] sd_addr_t;

    // ********************
    // Image layout
    // ********************

    // Each drive owns a fixed window of blocks on the card.
    // Within it, tracks follow each other, side 0 before side 1.
    localparam int unsigned drive_blocks = 1440;

    // ********************
    // Loader FSM
    // ********************

    // idle means no valid track is held, done means the buffer is valid.
    typedef enum logic [1:0] {
        idle,
        request,
        transfer,
        done
    } loader_state_t;

endpackage

/* logic/fdd_track.sv */
module fdd_track (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         msclk,
    input  fdd_geometry_pkg::drive_sel_t usel,
    input  logic                         readyn,
    input  logic                         stepn,
    input  logic                         sdirn,
    input  logic                         sidn,
    input  logic                         mount_valid,
    input  fdd_geometry_pkg::drive_sel_t mount_drive,
    input  logic                         mount_present,
    input  logic                         mount_sides,
    input  logic                         mount_readonly,
    output logic                         track0n,
    output logic                         wptn,
    output fdd_geometry_pkg::track_t     track,
    output logic                         track_ready,
    input  fdd_geometry_pkg::buf_addr_t  buffer_addr,
    output fdd_geometry_pkg::byte_t      buffer_q,
    output fdd_sd_pkg::lba_t             sd_lba,
    output fdd_sd_pkg::blk_cnt_t         sd_blk_cnt,
    output logic                         sd_rd,
    input  logic                         sd_ack,
    input  fdd_sd_pkg::sd_addr_t         sd_buff_addr,
    input  fdd_geometry_pkg::byte_t      sd_buff_dout,
    input  logic                         sd_buff_wr
);
    import fdd_geometry_pkg::*;

    logic      mounted;
    logic      double_sided;
    logic      read_only;
    logic      buf_we;
    buf_addr_t buf_waddr;

    head_stepper i_head_stepper (
        .clk       (clk),
        .reset     (reset),
        .msclk     (msclk),
        .drive     (usel),
        .stepn     (stepn),
        .sdirn     (sdirn),
        .cur_track (track)
    );

    media_table i_media_table (
        .clk            (clk),
        .reset          (reset),
        .drive          (usel),
        .mount_valid    (mount_valid),
        .mount_drive    (mount_drive),
        .mount_present  (mount_present),
        .mount_sides    (mount_sides),
        .mount_readonly (mount_readonly),
        .mounted        (mounted),
        .double_sided   (double_sided),
        .read_only      (read_only)
    );

    track_loader i_track_loader (
        .clk          (clk),
        .reset        (reset),
        .drive        (usel),
        .cur_track    (track),
        .sidn         (sidn),
        .mounted      (mounted),
        .double_sided (double_sided),
        .sd_lba       (sd_lba),
        .sd_blk_cnt   (sd_blk_cnt),
        .sd_rd        (sd_rd),
        .sd_ack       (sd_ack),
        .sd_buff_addr (sd_buff_addr),
        .sd_buff_wr   (sd_buff_wr),
        .buf_we       (buf_we),
        .buf_waddr    (buf_waddr),
        .ready        (track_ready)
    );

    track_buffer_ram i_track_buffer_ram (
        .clk   (clk),
        .we    (buf_we),
        .waddr (buf_waddr),
        .wdata (sd_buff_dout),
        .raddr (buffer_addr),
        .rdata (buffer_q)
    );

    // Track 0 is only reported to a drive that is selected as ready.
    assign track0n = (track != '0) || readyn;
    assign wptn    = ~read_only;

endmodule

/* logic/head_stepper.sv */
module head_stepper (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         msclk,
    input  fdd_geometry_pkg::drive_sel_t drive,
    input  logic                         stepn,
    input  logic                         sdirn,
    output fdd_geometry_pkg::track_t     cur_track
);
    import fdd_geometry_pkg::*;

    track_t     pos [num_drives];
    logic       stepn_r;
    logic       stepn_d;
    logic [2:0] lockout;
    logic       step;

    // Falling edge of the registered step line, only outside the lockout.
    assign step = stepn_d & ~stepn_r & (lockout == '0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            foreach (pos[i]) begin
                pos[i] <= track_t'(reset_track);
            end
            stepn_r <= 1'b1;
            stepn_d <= 1'b1;
            lockout <= '0;
        end else begin
            stepn_r <= stepn;
            stepn_d <= stepn_r;

            if (step) begin
                lockout <= 3'(step_delay_ms);
                if (sdirn) begin
                    // Inward, towards higher cylinders.
                    if (pos[drive] < track_t'(max_track)) begin
                        pos[drive] <= pos[drive] + 1'b1;
                    end
                end else begin
                    if (pos[drive] != '0) begin
                        pos[drive] <= pos[drive] - 1'b1;
                    end
                end
            end else if (msclk && lockout != '0) begin
                lockout <= lockout - 1'b1;
            end
        end
    end

    assign cur_track = pos[drive];

endmodule

/* logic/media_table.sv */
module media_table (
    input  logic                         clk,
    input  logic                         reset,
    input  fdd_geometry_pkg::drive_sel_t drive,
    input  logic                         mount_valid,
    input  fdd_geometry_pkg::drive_sel_t mount_drive,
    input  logic                         mount_present,
    input  logic                         mount_sides,
    input  logic                         mount_readonly,
    output logic                         mounted,
    output logic                         double_sided,
    output logic                         read_only
);
    import fdd_geometry_pkg::*;

    logic [num_drives-1:0] present;
    logic [num_drives-1:0] sides;
    logic [num_drives-1:0] ro_flags;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            present  <= '0;
            sides    <= '0;
            ro_flags <= '0;
        end else if (mount_valid) begin
            // An eject clears the properties of that slot too.
            present[mount_drive]  <= mount_present;
            sides[mount_drive]    <= mount_present & mount_sides;
            ro_flags[mount_drive] <= mount_present & mount_readonly;
        end
    end

    assign mounted      = present[drive];
    assign double_sided = sides[drive];
    assign read_only    = ro_flags[drive];

endmodule

/* logic/track_buffer_ram.sv */
module track_buffer_ram (
    input  logic                        clk,
    input  logic                        we,
    input  fdd_geometry_pkg::buf_addr_t waddr,
    input  fdd_geometry_pkg::byte_t     wdata,
    input  fdd_geometry_pkg::buf_addr_t raddr,
    output fdd_geometry_pkg::byte_t     rdata
);
    import fdd_geometry_pkg::*;

    byte_t mem [track_bytes];

    // SD side writes, host side reads one cycle later.
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];
    end

endmodule

/* logic/track_loader.sv */
module track_loader (
    input  logic                         clk,
    input  logic                         reset,
    input  fdd_geometry_pkg::drive_sel_t drive,
    input  fdd_geometry_pkg::track_t     cur_track,
    input  logic                         sidn,
    input  logic                         mounted,
    input  logic                         double_sided,
    output fdd_sd_pkg::lba_t             sd_lba,
    output fdd_sd_pkg::blk_cnt_t         sd_blk_cnt,
    output logic                         sd_rd,
    input  logic                         sd_ack,
    input  fdd_sd_pkg::sd_addr_t         sd_buff_addr,
    input  logic                         sd_buff_wr,
    output logic                         buf_we,
    output fdd_geometry_pkg::buf_addr_t  buf_waddr,
    output logic                         ready
);
    import fdd_geometry_pkg::*;
    import fdd_sd_pkg::*;

    loader_state_t state;
    logic          side;
    logic          changed;
    logic          stale;
    lba_t          lba_next;

    // Drive, track, side and mounted flag of the wanted track.
    logic [$bits(drive_sel_t) + $bits(track_t) + 1:0] target;
    logic [$bits(drive_sel_t) + $bits(track_t) + 1:0] loaded_target;

    assign side    = double_sided & ~sidn;
    assign target  = {drive, cur_track, side, mounted};
    // A remount shows up here through the mounted bit.
    assign changed = target != loaded_target;

    always_comb begin
        if (double_sided) begin
            lba_next = lba_t'(drive) * drive_blocks
                     + lba_t'({cur_track, side}) * sectors_per_track;
        end else begin
            lba_next = lba_t'(drive) * drive_blocks
                     + lba_t'(cur_track) * sectors_per_track;
        end
    end

    assign sd_blk_cnt = blk_cnt_t'(sectors_per_track);

    // ********************
    // Load FSM
    // ********************

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state         <= idle;
            sd_rd         <= 1'b0;
            sd_lba        <= '0;
            ready         <= 1'b0;
            stale         <= 1'b0;
            loaded_target <= '0;
        end else begin
            case (state)
                idle, done: begin
                    if (changed) begin
                        ready         <= 1'b0;
                        loaded_target <= target;
                        if (mounted) begin
                            sd_lba <= lba_next;
                            sd_rd  <= 1'b1;
                            state  <= request;
                        end else begin
                            state <= idle;
                        end
                    end
                end
                request: begin
                    stale <= stale | changed;
                    if (sd_ack) begin
                        sd_rd <= 1'b0;
                        state <= transfer;
                    end
                end
                transfer: begin
                    if (!sd_ack) begin
                        stale <= 1'b0;
                        if (stale || changed) begin
                            // Buffer holds an old track, go again right away.
                            loaded_target <= target;
                            if (mounted) begin
                                sd_lba <= lba_next;
                                sd_rd  <= 1'b1;
                                state  <= request;
                            end else begin
                                state <= idle;
                            end
                        end else begin
                            ready <= 1'b1;
                            state <= done;
                        end
                    end else begin
                        stale <= stale | changed;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // Blocks past the track end are dropped.
    assign buf_we    = sd_ack & sd_buff_wr & (sd_buff_addr < sd_addr_t'(track_bytes));
    assign buf_waddr = buf_addr_t'(sd_buff_addr);

endmodule

/* sim/sd_card_model.sv */
module sd_card_model (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    sd_rd,
    input  fdd_sd_pkg::lba_t        sd_lba,
    input  fdd_sd_pkg::blk_cnt_t    sd_blk_cnt,
    output logic                    sd_ack,
    output fdd_sd_pkg::sd_addr_t    sd_buff_addr,
    output fdd_geometry_pkg::byte_t sd_buff_dout,
    output logic                    sd_buff_wr
);
    timeunit 1ns;
    timeprecision 100ps;
    import fdd_geometry_pkg::*;
    import fdd_sd_pkg::*;

    lba_t        lba;
    int unsigned total;
    int unsigned delay;

    initial begin
        void'($urandom(32'he63b_ebc2));
        sd_ack       = 1'b0;
        sd_buff_addr = '0;
        sd_buff_dout = '0;
        sd_buff_wr   = 1'b0;
        forever begin
            @(posedge clk);
            if (!reset && sd_rd && !sd_ack) begin
                lba   = sd_lba;
                total = sd_blk_cnt * 512;
                delay = 1 + ($urandom % 20);
                #1 sd_ack = 1'b1;
                repeat (delay) @(posedge clk);
                // One byte per clock, value taken from block address and offset.
                for (int unsigned i = 0; i < total; i++) begin
                    #1;
                    sd_buff_wr   = 1'b1;
                    sd_buff_addr = sd_addr_t'(i);
                    sd_buff_dout = byte_t'(lba + i);
                    @(posedge clk);
                end
                #1;
                sd_buff_wr = 1'b0;
                sd_ack     = 1'b0;
            end
        end
    end

endmodule

/* sim/tb_fdd_track.sv */
module tb_fdd_track;
    timeunit 1ns;
    timeprecision 100ps;
    import fdd_geometry_pkg::*;
    import fdd_sd_pkg::*;

    // Clock cycles between two msclk pulses.
    localparam int unsigned ms_cycles = 50;
    // The tests need about 50k cycles, the rest is margin.
    localparam int unsigned timeout_cycles = 200000;

    logic        clk = 1'b0;
    logic        reset;
    logic        msclk;
    drive_sel_t  usel;
    logic        readyn;
    logic        stepn;
    logic        sdirn;
    logic        sidn;
    logic        mount_valid;
    drive_sel_t  mount_drive;
    logic        mount_present;
    logic        mount_sides;
    logic        mount_readonly;
    logic        track0n;
    logic        wptn;
    track_t      track;
    logic        track_ready;
    buf_addr_t   buffer_addr;
    byte_t       buffer_q;
    lba_t        sd_lba;
    blk_cnt_t    sd_blk_cnt;
    logic        sd_rd;
    logic        sd_ack;
    sd_addr_t    sd_buff_addr;
    byte_t       sd_buff_dout;
    logic        sd_buff_wr;
    track_t      exp_track [num_drives];
    int unsigned cycles = 0;

    fdd_track i_fdd_track (.*);

    sd_card_model i_sd_card_model (.*);

    always #4 clk = ~clk;

    initial begin
        msclk = 1'b0;
        forever begin
            repeat (ms_cycles - 1) @(posedge clk);
            #1 msclk = 1'b1;
            @(posedge clk);
            #1 msclk = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles == timeout_cycles) begin
            fail_run($sformatf("Run did not finish within %0d clock cycles", timeout_cycles));
        end
    end

    // ********************
    // Helpers
    // ********************

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_track(input track_t got, input track_t exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at %0t: %s, got %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic check_byte(input byte_t got, input byte_t exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_lba(input lba_t got, input lba_t exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at %0t: %s, got %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic check_blk_cnt(input blk_cnt_t got, input blk_cnt_t exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at %0t: %s, got %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at %0t: %s, got %b, expected %b", $time, what, got, exp));
        end
    endtask

    // Image layout: each drive owns drive_blocks, nine blocks per track side.
    function automatic lba_t layout_lba(input drive_sel_t drv, input track_t trk, input logic side,
                                        input logic two_sides);
        int unsigned first;
        first = drv * drive_blocks;
        if (two_sides) begin
            layout_lba = lba_t'(first + (trk * 2 + side) * sectors_per_track);
        end else begin
            layout_lba = lba_t'(first + trk * sectors_per_track);
        end
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // The head moves on the second edge after stepn falls.
    task automatic step_head(input logic inward, input logic expect_move);
        sdirn = inward;
        stepn = 1'b0;
        tick();
        tick();
        stepn = 1'b1;
        if (expect_move && inward && exp_track[usel] < max_track) begin
            exp_track[usel] = exp_track[usel] + 1'b1;
        end else if (expect_move && !inward && exp_track[usel] != 0) begin
            exp_track[usel] = exp_track[usel] - 1'b1;
        end
        check_track(track, exp_track[usel], "head position after step");
        tick();
    endtask

    task automatic wait_lockout();
        repeat ((step_delay_ms + 1) * ms_cycles) tick();
    endtask

    task automatic mount_disk(input drive_sel_t drv, input logic present, input logic sides,
                              input logic ro);
        mount_drive    = drv;
        mount_present  = present;
        mount_sides    = sides;
        mount_readonly = ro;
        mount_valid    = 1'b1;
        tick();
        mount_valid = 1'b0;
    endtask

    // Track must stay not ready until the loader asks the card.
    task automatic wait_request(input lba_t exp);
        while (!sd_rd) begin
            check_flag(track_ready, 1'b0, "track_ready before request");
            tick();
        end
        check_lba(sd_lba, exp, "sd_lba of request");
        check_blk_cnt(sd_blk_cnt, blk_cnt_t'(9), "sd_blk_cnt of request");
    endtask

    task automatic wait_ready();
        while (!track_ready) begin
            tick();
        end
    endtask

    task automatic check_buffer(input lba_t lba);
        for (int unsigned i = 0; i < track_bytes; i++) begin
            buffer_addr = buf_addr_t'(i);
            tick();
            check_byte(buffer_q, byte_t'(lba + i), "track buffer byte");
        end
    endtask

    // ********************
    // Tests
    // ********************

    task automatic test_step_to_track0();
        usel = 2'd0;
        tick();
        check_track(track, track_t'(reset_track), "track after reset");
        check_flag(track_ready, 1'b0, "track_ready after reset");
        check_flag(track0n, 1'b1, "track0n after reset");
        repeat (3) begin
            step_head(1'b0, 1'b1);
            wait_lockout();
        end
        check_flag(track0n, 1'b1, "track0n with readyn high");
        readyn = 1'b0;
        tick();
        check_flag(track0n, 1'b0, "track0n at track 0");
        step_head(1'b0, 1'b1);
        wait_lockout();
    endtask

    task automatic test_lockout_and_limit();
        step_head(1'b1, 1'b1);
        step_head(1'b1, 1'b0);
        wait_lockout();
        usel = 2'd2;
        tick();
        repeat (max_track + 2 - reset_track) begin
            step_head(1'b1, 1'b1);
            wait_lockout();
        end
        check_track(track, track_t'(max_track), "head at inner limit");
    endtask

    task automatic test_per_drive_heads();
        usel = 2'd1;
        repeat (2) begin
            step_head(1'b1, 1'b1);
            wait_lockout();
        end
        usel = 2'd0;
        tick();
        check_track(track, exp_track[0], "drive 0 head after drive 1 steps");
        usel = 2'd1;
        tick();
        check_track(track, exp_track[1], "drive 1 head");
    endtask

    task automatic test_double_sided_load();
        lba_t lba;
        sidn = 1'b0;
        lba  = layout_lba(2'd1, exp_track[1], 1'b1, 1'b1);
        mount_disk(2'd1, 1'b1, 1'b1, 1'b0);
        wait_request(lba);
        check_flag(wptn, 1'b1, "wptn on writable disk");
        wait_ready();
        check_buffer(lba);
    endtask

    task automatic test_single_sided_and_eject();
        lba_t lba;
        usel = 2'd3;
        sidn = 1'b0;
        lba  = layout_lba(2'd3, exp_track[3], 1'b0, 1'b0);
        mount_disk(2'd3, 1'b1, 1'b0, 1'b1);
        wait_request(lba);
        check_flag(wptn, 1'b0, "wptn on read-only disk");
        wait_ready();
        sidn = 1'b1;
        repeat (4) tick();
        check_flag(track_ready, 1'b1, "track_ready after sidn change on single side");
        check_flag(sd_rd, 1'b0, "sd_rd after sidn change on single side");
        mount_disk(2'd3, 1'b0, 1'b0, 1'b0);
        tick();
        repeat (20) begin
            check_flag(track_ready, 1'b0, "track_ready on ejected drive");
            check_flag(sd_rd, 1'b0, "sd_rd on ejected drive");
            tick();
        end
        check_flag(wptn, 1'b1, "wptn on ejected drive");
    endtask

    task automatic test_change_during_transfer();
        usel = 2'd1;
        sidn = 1'b1;
        wait_request(layout_lba(2'd1, exp_track[1], 1'b0, 1'b1));
        while (!sd_ack) begin
            tick();
        end
        step_head(1'b1, 1'b1);
        wait_request(layout_lba(2'd1, exp_track[1], 1'b0, 1'b1));
        wait_ready();
        check_buffer(layout_lba(2'd1, exp_track[1], 1'b0, 1'b1));
    endtask

    initial begin
        reset          = 1'b1;
        usel           = '0;
        readyn         = 1'b1;
        stepn          = 1'b1;
        sdirn          = 1'b0;
        sidn           = 1'b1;
        mount_valid    = 1'b0;
        mount_drive    = '0;
        mount_present  = 1'b0;
        mount_sides    = 1'b0;
        mount_readonly = 1'b0;
        buffer_addr    = '0;
        foreach (exp_track[i]) begin
            exp_track[i] = track_t'(reset_track);
        end
        repeat (16) tick();
        reset = 1'b0;
        tick();
        test_step_to_track0();
        test_lockout_and_limit();
        test_per_drive_heads();
        test_double_sided_load();
        test_single_sided_and_eject();
        test_change_during_transfer();
        $display("all tests passed");
        $finish;
    end

endmodule
